//--- dcache_wbuf_sva.sv
`default_nettype none

module dcache_wbuf_sva (
    input wire logic clk,
    input wire logic rst,
    input wire logic cpu_rreq_i,
    input wire logic mem_ready_i,
    input wire logic mem_wen_i,
    input wire logic full_i,
    input wire logic empty_i,
    input wire logic read_hit_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // a line goes out only when memory is free and one is queued
    send_needs_ready: assert property (@(posedge clk) disable iff (rst)
        mem_wen_i |-> (mem_ready_i && !empty_i))
        else $error("mem_wen_o high without mem_ready_i or with an empty queue");

    levels_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(full_i && empty_i))
        else $error("full_o and empty_o high together");

    // read answer only follows a request
    hit_needs_request: assert property (@(posedge clk) disable iff (rst)
        !cpu_rreq_i |=> !read_hit_i)
        else $error("read_hit_o high after a cycle without cpu_rreq_i");

endmodule

bind dcache_wbuf_top dcache_wbuf_sva i_sva (
    .clk         (clk),
    .rst         (rst),
    .cpu_rreq_i  (cpu_rreq_i),
    .mem_ready_i (mem_ready_i),
    .mem_wen_i   (mem_wen_o),
    .full_i      (full_o),
    .empty_i     (empty_o),
    .read_hit_i  (read_hit_o)
);

`default_nettype wire

//--- dcache_wbuf_top.sv
`default_nettype none

`include "wbuf_defs.svh"

module dcache_wbuf_top (
    input  wire logic                     clk,
    input  wire logic                     rst,
    // cache write
    input  wire logic                     cpu_wreq_i,
    input  wire wbuf_pkg::wbuf_addr_t     cpu_awaddr_i,
    input  wire logic [`WBUF_LINE_W-1:0]  cpu_wdata_i,
    output logic                          write_hit_o,
    // cache read
    input  wire logic                     cpu_rreq_i,
    input  wire wbuf_pkg::wbuf_addr_t     cpu_araddr_i,
    output logic                          read_hit_o,
    output logic [`WBUF_WORD_W-1:0]       cpu_rdata_o,
    // queue levels
    output logic                          full_o,
    output logic                          empty_o,
    // memory side
    input  wire logic                     mem_ready_i,
    output logic                          mem_wen_o,
    output wbuf_pkg::wbuf_addr_t          mem_awaddr_o,
    output logic [`WBUF_LINE_W-1:0]       mem_wdata_o
);

    logic [`WBUF_DEPTH-1:0]                   wr_hit_vec;
    wbuf_pkg::wbuf_idx_t                      wr_hit_idx;
    logic [`WBUF_DEPTH-1:0]                   rd_hit_vec;
    logic [`WBUF_DEPTH-1:0]                   q_valid;
    logic [`WBUF_DEPTH-1:0][`WBUF_LNUM_W-1:0] q_line;
    wbuf_pkg::wbuf_idx_t                      ram_widx;
    wbuf_pkg::wbuf_idx_t                      head;
    wbuf_pkg::wbuf_idx_t                      rd_idx;
    logic [`WBUF_LINE_W-1:0]                  rd_line;

    wbuf_addr_match u_match (
        .cpu_wreq_i   (cpu_wreq_i),
        .cpu_awaddr_i (cpu_awaddr_i),
        .cpu_rreq_i   (cpu_rreq_i),
        .cpu_araddr_i (cpu_araddr_i),
        .q_valid_i    (q_valid),
        .q_line_i     (q_line),
        .wr_hit_vec_o (wr_hit_vec),
        .wr_hit_o     (write_hit_o),
        .wr_hit_idx_o (wr_hit_idx),
        .rd_hit_vec_o (rd_hit_vec)
    );

    wbuf_queue_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_wreq_i   (cpu_wreq_i),
        .cpu_awaddr_i (cpu_awaddr_i),
        .wr_hit_i     (write_hit_o),
        .wr_hit_idx_i (wr_hit_idx),
        .wr_hit_vec_i (wr_hit_vec),
        .mem_ready_i  (mem_ready_i),
        .q_valid_o    (q_valid),
        .q_line_o     (q_line),
        .ram_widx_o   (ram_widx),
        .head_o       (head),
        .full_o       (full_o),
        .empty_o      (empty_o),
        .mem_wen_o    (mem_wen_o),
        .mem_awaddr_o (mem_awaddr_o)
    );

    // port a serves cache reads, port b the memory send
    wbuf_line_ram #(
        .DEPTH (`WBUF_DEPTH),
        .WIDTH (`WBUF_LINE_W)
    ) u_ram (
        .clk       (clk),
        .we_i      (cpu_wreq_i),
        .widx_i    (ram_widx),
        .wdata_i   (cpu_wdata_i),
        .ridx_a_i  (rd_idx),
        .ridx_b_i  (head),
        .rdata_a_o (rd_line),
        .rdata_b_o (mem_wdata_o)
    );

    wbuf_read_port u_rd (
        .clk          (clk),
        .rst          (rst),
        .rd_hit_vec_i (rd_hit_vec),
        .cpu_rreq_i   (cpu_rreq_i),
        .cpu_araddr_i (cpu_araddr_i),
        .line_i       (rd_line),
        .read_hit_o   (read_hit_o),
        .rd_idx_o     (rd_idx),
        .cpu_rdata_o  (cpu_rdata_o)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the write buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_dcache_wbuf -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Test passed$"; then
    exit 0
fi
exit 1

//--- tb.f
+incdir+.
wbuf_pkg.sv
wbuf_addr_match.sv
wbuf_line_ram.sv
wbuf_queue_ctrl.sv
wbuf_read_port.sv
dcache_wbuf_top.sv
dcache_wbuf_sva.sv
tb_dcache_wbuf.sv

//--- tb_dcache_wbuf.sv
`default_nettype none

`include "wbuf_defs.svh"

module tb_dcache_wbuf;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ADDR_W = `WBUF_ADDR_W;
    localparam int OFFSET_W = `WBUF_OFFSET_W;
    localparam int LNUM_W = `WBUF_LNUM_W;
    localparam int LINE_W = `WBUF_LINE_W;
    localparam int WORD_W = `WBUF_WORD_W;
    localparam int LINE_POOL = 6;
    localparam int DRAIN_LIMIT = 64;

    typedef logic [LNUM_W-1:0] lnum_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // pool spread over high and low line bits
    localparam lnum_t LINE_BASE = 28'h0a5c300;
    localparam lnum_t LINE_STEP = 28'h0101011;

    logic              clk;
    logic              rst;
    logic              cpu_wreq;
    logic [ADDR_W-1:0] cpu_awaddr;
    logic [LINE_W-1:0] cpu_wdata;
    logic              write_hit;
    logic              cpu_rreq;
    logic [ADDR_W-1:0] cpu_araddr;
    logic              read_hit;
    logic [WORD_W-1:0] cpu_rdata;
    logic              full;
    logic              empty;
    logic              mem_ready;
    logic              mem_wen;
    logic [ADDR_W-1:0] mem_awaddr;
    logic [LINE_W-1:0] mem_wdata;

    // reference queue, oldest line first
    lnum_t             m_line [$];
    logic [LINE_W-1:0] m_data [$];
    logic              m_rewrite;
    logic              exp_rd_hit;
    logic [WORD_W-1:0] exp_rd_data;
    int                n_merge;
    int                n_resend;
    int                n_full;
    int                n_rd_hit;

    dcache_wbuf_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .cpu_wreq_i   (cpu_wreq),
        .cpu_awaddr_i (cpu_awaddr),
        .cpu_wdata_i  (cpu_wdata),
        .write_hit_o  (write_hit),
        .cpu_rreq_i   (cpu_rreq),
        .cpu_araddr_i (cpu_araddr),
        .read_hit_o   (read_hit),
        .cpu_rdata_o  (cpu_rdata),
        .full_o       (full),
        .empty_o      (empty),
        .mem_ready_i  (mem_ready),
        .mem_wen_o    (mem_wen),
        .mem_awaddr_o (mem_awaddr),
        .mem_wdata_o  (mem_wdata)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [LINE_W-1:0] expected,
                               input logic [LINE_W-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            stop_with_failure("value mismatch");
        end
    endtask

    function automatic int find_line(input lnum_t ln);
        int idx;
        idx = -1;
        foreach (m_line[i]) begin
            if (m_line[i] == ln) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic pick_inputs(input int ready_pct, input bit allow_req);
        lnum_t wl;
        lnum_t rl;
        wl = LINE_BASE + LINE_STEP * lnum_t'($urandom_range(LINE_POOL - 1));
        rl = LINE_BASE + LINE_STEP * lnum_t'($urandom_range(LINE_POOL - 1));
        cpu_awaddr = {wl, offset_t'($urandom_range(15))};
        cpu_araddr = {rl, offset_t'($urandom_range(15))};
        cpu_wdata  = {$urandom, $urandom, $urandom, $urandom};
        cpu_wreq   = allow_req && ($urandom_range(99) < 50);
        cpu_rreq   = allow_req && ($urandom_range(99) < 50);
        mem_ready  = ($urandom_range(99) < ready_pct);
        // the cache never pushes a new line into a full queue
        if (find_line(wl) < 0 && m_line.size() == `WBUF_DEPTH) begin
            cpu_wreq = 1'b0;
        end
    endtask

    task automatic check_outputs();
        bit sending;
        sending = mem_ready && m_line.size() != 0;
        if (m_line.size() == `WBUF_DEPTH) begin
            n_full++;
        end
        check_value("write_hit", cpu_wreq && find_line(cpu_awaddr[ADDR_W-1:OFFSET_W]) >= 0,
                    write_hit);
        check_value("full", m_line.size() == `WBUF_DEPTH, full);
        check_value("empty", m_line.size() == 0, empty);
        check_value("mem_wen", sending, mem_wen);
        if (sending) begin
            check_value("send_addr", {m_line[0], offset_t'(0)}, mem_awaddr);
            check_value("send_data", m_data[0], mem_wdata);
        end
        check_value("read_hit", exp_rd_hit, read_hit);
        check_value("read_data", exp_rd_data, cpu_rdata);
    endtask

    // state after the coming edge, plus the read answer for the next cycle
    task automatic update_model();
        int                wi;
        int                ri;
        int                wsel;
        bit                pop;
        logic [LINE_W-1:0] ln;
        wi   = cpu_wreq ? find_line(cpu_awaddr[ADDR_W-1:OFFSET_W]) : -1;
        ri   = cpu_rreq ? find_line(cpu_araddr[ADDR_W-1:OFFSET_W]) : -1;
        wsel = int'(cpu_araddr[OFFSET_W-1:`WBUF_BYTE_W]);
        pop  = mem_ready && m_line.size() != 0 && !m_rewrite && wi != 0;
        if (mem_ready && m_line.size() != 0 && !pop) begin
            n_resend++;
        end
        if (mem_ready) begin
            m_rewrite = 1'b0;
        end else if (wi == 0) begin
            m_rewrite = 1'b1;
        end
        if (wi >= 0) begin
            m_data[wi] = cpu_wdata;
            n_merge++;
        end else if (cpu_wreq) begin
            m_line.push_back(cpu_awaddr[ADDR_W-1:OFFSET_W]);
            m_data.push_back(cpu_wdata);
        end
        exp_rd_hit  = (ri >= 0);
        exp_rd_data = '0;
        if (ri >= 0) begin
            ln          = m_data[ri];
            exp_rd_data = ln[wsel * WORD_W +: WORD_W];
            n_rd_hit++;
        end
        if (pop) begin
            void'(m_line.pop_front());
            void'(m_data.pop_front());
        end
    endtask

    task automatic run_cycle(input int ready_pct, input bit allow_req);
        @(posedge clk);
        #1;
        pick_inputs(ready_pct, allow_req);
        #1;
        check_outputs();
        update_model();
    endtask

    initial begin
        int drain_cycles;
        void'($urandom(37141));
        rst         = 1'b1;
        cpu_wreq    = 1'b0;
        cpu_awaddr  = '0;
        cpu_wdata   = '0;
        cpu_rreq    = 1'b0;
        cpu_araddr  = '0;
        mem_ready   = 1'b0;
        m_rewrite   = 1'b0;
        exp_rd_hit  = 1'b0;
        exp_rd_data = '0;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        #1;
        check_value("reset_empty", 1'b1, empty);
        check_value("reset_full", 1'b0, full);
        check_value("reset_mem_wen", 1'b0, mem_wen);
        check_value("reset_read_hit", 1'b0, read_hit);
        // memory mostly busy, so the queue fills
        for (int i = 0; i < 400; i++) begin
            run_cycle(10, 1'b1);
        end
        for (int i = 0; i < 3000; i++) begin
            run_cycle(40, 1'b1);
        end
        // requests stop first, then the queue must empty
        drain_cycles = 0;
        do begin
            if (drain_cycles == DRAIN_LIMIT) begin
                stop_with_failure("write buffer did not drain to memory in time");
            end
            run_cycle(100, 1'b0);
            drain_cycles++;
        end while (!empty);
        if (n_merge == 0 || n_resend == 0 || n_full == 0 || n_rd_hit == 0) begin
            stop_with_failure("random stimulus missed merge, resend, full or read hit cases");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- wbuf_addr_match.sv
`default_nettype none

`include "wbuf_defs.svh"

module wbuf_addr_match (
    // cache write side
    input  wire logic                                     cpu_wreq_i,
    input  wire wbuf_pkg::wbuf_addr_t                     cpu_awaddr_i,
    // cache read side
    input  wire logic                                     cpu_rreq_i,
    input  wire wbuf_pkg::wbuf_addr_t                     cpu_araddr_i,
    // queue contents from control
    input  wire logic [`WBUF_DEPTH-1:0]                   q_valid_i,
    input  wire logic [`WBUF_DEPTH-1:0][`WBUF_LNUM_W-1:0] q_line_i,
    // match results
    output logic [`WBUF_DEPTH-1:0]                        wr_hit_vec_o,
    output logic                                          wr_hit_o,
    output wbuf_pkg::wbuf_idx_t                           wr_hit_idx_o,
    output logic [`WBUF_DEPTH-1:0]                        rd_hit_vec_o
);

    // per-slot compare on the line number, offset ignored
    always_comb begin
        for (int i = 0; i < `WBUF_DEPTH; i++) begin
            wr_hit_vec_o[i] = cpu_wreq_i && q_valid_i[i]
                              && (q_line_i[i] == cpu_awaddr_i.lv.line);
            rd_hit_vec_o[i] = cpu_rreq_i && q_valid_i[i]
                              && (q_line_i[i] == cpu_araddr_i.lv.line);
        end
    end

    // a line sits in at most one slot, so the vector is one-hot
    assign wr_hit_o = |wr_hit_vec_o;

    assign wr_hit_idx_o = wbuf_pkg::hit_to_idx(wr_hit_vec_o);

endmodule

`default_nettype wire

//--- wbuf_defs.svh
`ifndef WBUF_DEFS_SVH
`define WBUF_DEFS_SVH

// queue entries, power of two
`define WBUF_DEPTH 4

// byte address width
`define WBUF_ADDR_W 32

// one cache line, four words
`define WBUF_LINE_W 128

// read return width
`define WBUF_WORD_W 32

// address split for a 16-byte line
`define WBUF_OFFSET_W 4
`define WBUF_LNUM_W (`WBUF_ADDR_W - `WBUF_OFFSET_W)
`define WBUF_WSEL_W 2
`define WBUF_BYTE_W 2

// queue index width
`define WBUF_IDX_W $clog2(`WBUF_DEPTH)

`endif

//--- wbuf_line_ram.sv
`default_nettype none

`include "wbuf_defs.svh"

module wbuf_line_ram #(
    parameter int DEPTH = `WBUF_DEPTH,
    parameter int WIDTH = `WBUF_LINE_W
) (
    input  wire logic                     clk,
    // write port
    input  wire logic                     we_i,
    input  wire logic [$clog2(DEPTH)-1:0] widx_i,
    input  wire logic [WIDTH-1:0]         wdata_i,
    // two combinational read ports
    input  wire logic [$clog2(DEPTH)-1:0] ridx_a_i,
    input  wire logic [$clog2(DEPTH)-1:0] ridx_b_i,
    output logic [WIDTH-1:0]              rdata_a_o,
    output logic [WIDTH-1:0]              rdata_b_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[widx_i] <= wdata_i;
        end
    end

    // reads see the old line in the cycle of a write
    assign rdata_a_o = mem[ridx_a_i];
    assign rdata_b_o = mem[ridx_b_i];

endmodule

`default_nettype wire

//--- wbuf_pkg.sv
`default_nettype none

`include "wbuf_defs.svh"

package wbuf_pkg;

    // line number plus byte offset inside the line
    typedef struct packed {
        logic [`WBUF_LNUM_W-1:0]   line;
        logic [`WBUF_OFFSET_W-1:0] offset;
    } wbuf_line_view_t;

    // same address split down to a word inside the line
    typedef struct packed {
        logic [`WBUF_LNUM_W-1:0] line;
        logic [`WBUF_WSEL_W-1:0] word_sel;
        logic [`WBUF_BYTE_W-1:0] byte_idx;
    } wbuf_word_view_t;

    typedef union packed {
        wbuf_line_view_t lv;
        wbuf_word_view_t wv;
    } wbuf_addr_t;

    typedef logic [`WBUF_IDX_W-1:0] wbuf_idx_t;

    // one-hot hit vector to slot index, highest set bit wins
    function automatic wbuf_idx_t hit_to_idx(input logic [`WBUF_DEPTH-1:0] vec);
        wbuf_idx_t idx;
        idx = '0;
        for (int i = 0; i < `WBUF_DEPTH; i++) begin
            if (vec[i]) begin
                idx = wbuf_idx_t'(i);
            end
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

//--- wbuf_queue_ctrl.sv
`default_nettype none

`include "wbuf_defs.svh"

module wbuf_queue_ctrl (
    input  wire logic                                     clk,
    input  wire logic                                     rst,
    // cache write and its match result
    input  wire logic                                     cpu_wreq_i,
    input  wire wbuf_pkg::wbuf_addr_t                     cpu_awaddr_i,
    input  wire logic                                     wr_hit_i,
    input  wire wbuf_pkg::wbuf_idx_t                      wr_hit_idx_i,
    input  wire logic [`WBUF_DEPTH-1:0]                   wr_hit_vec_i,
    // memory side
    input  wire logic                                     mem_ready_i,
    // queue contents for the matcher
    output logic [`WBUF_DEPTH-1:0]                        q_valid_o,
    output logic [`WBUF_DEPTH-1:0][`WBUF_LNUM_W-1:0]      q_line_o,
    // line storage indexes
    output wbuf_pkg::wbuf_idx_t                           ram_widx_o,
    output wbuf_pkg::wbuf_idx_t                           head_o,
    // levels and send
    output logic                                          full_o,
    output logic                                          empty_o,
    output logic                                          mem_wen_o,
    output wbuf_pkg::wbuf_addr_t                          mem_awaddr_o
);

    wbuf_pkg::wbuf_idx_t                  head;
    wbuf_pkg::wbuf_idx_t                  tail;
    logic [`WBUF_DEPTH-1:0]               valid;
    logic [`WBUF_DEPTH-1:0][`WBUF_LNUM_W-1:0] line_q;
    logic                                 rewrite;
    logic                                 head_hit;
    logic                                 push;
    logic                                 pop;

    // match vector is already gated by the write request
    assign head_hit = wr_hit_vec_i[head];
    assign push     = cpu_wreq_i && !wr_hit_i;

    // send whenever memory is free and the head holds a line
    assign mem_wen_o = mem_ready_i && valid[head];

    // keep the head if newer data is pending or arriving now
    assign pop = mem_wen_o && !rewrite && !head_hit;

    // valid slots stay contiguous from head to tail
    assign full_o  = valid[tail];
    assign empty_o = !valid[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            valid <= '0;
        end else begin
            if (pop) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end
            if (push) begin
                valid[tail] <= 1'b1;
                tail        <= tail + 1'b1;
            end
        end
    end

    // line numbers of queued entries
    always_ff @(posedge clk) begin
        if (push) begin
            line_q[tail] <= cpu_awaddr_i.lv.line;
        end
    end

    // head was rewritten while memory was busy
    always_ff @(posedge clk) begin
        if (rst) begin
            rewrite <= 1'b0;
        end else if (mem_ready_i) begin
            rewrite <= 1'b0;
        end else if (head_hit) begin
            rewrite <= 1'b1;
        end
    end

    // merge into the hit slot, otherwise append at tail
    assign ram_widx_o = wr_hit_i ? wr_hit_idx_i : tail;
    assign head_o     = head;

    assign q_valid_o = valid;
    assign q_line_o  = line_q;

    always_comb begin
        mem_awaddr_o         = '0;
        mem_awaddr_o.lv.line = line_q[head];
    end

endmodule

`default_nettype wire

//--- wbuf_read_port.sv
`default_nettype none

`include "wbuf_defs.svh"

module wbuf_read_port (
    input  wire logic                     clk,
    input  wire logic                     rst,
    // lookup from the matcher
    input  wire logic [`WBUF_DEPTH-1:0]   rd_hit_vec_i,
    input  wire logic                     cpu_rreq_i,
    input  wire wbuf_pkg::wbuf_addr_t     cpu_araddr_i,
    // line read back from storage
    input  wire logic [`WBUF_LINE_W-1:0]  line_i,
    // response, one cycle after the request
    output logic                          read_hit_o,
    output wbuf_pkg::wbuf_idx_t           rd_idx_o,
    output logic [`WBUF_WORD_W-1:0]       cpu_rdata_o
);

    logic [`WBUF_DEPTH-1:0]  hit_q;
    logic [`WBUF_WSEL_W-1:0] wsel_q;

    // hit vector is zero without a request, so read_hit drops too
    always_ff @(posedge clk) begin
        if (rst) begin
            hit_q <= '0;
        end else begin
            hit_q <= rd_hit_vec_i;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_rreq_i) begin
            wsel_q <= cpu_araddr_i.wv.word_sel;
        end
    end

    assign read_hit_o = |hit_q;
    assign rd_idx_o   = wbuf_pkg::hit_to_idx(hit_q);

    // word 0 sits in the low bits of the line
    assign cpu_rdata_o = read_hit_o ? line_i[wsel_q * `WBUF_WORD_W +: `WBUF_WORD_W] : '0;

endmodule

`default_nettype wire
